//--- rtl/mcu_pkg.sv
`default_nettype none

package mcu_pkg;

  localparam int ADDR_W   = 24;
  localparam int CREDIT_W = 3;

  // position of a byte in its frame, 0 is the command byte
  typedef logic [3:0] byte_idx_t;
  localparam byte_idx_t IDX_MAX = 4'd15;

  typedef enum logic [3:0] {
    NONE      = 4'd0,
    SET_ADDR  = 4'd1,
    ROM_MASK  = 4'd2,
    SRAM_MASK = 4'd3,
    MAPPER    = 4'd4,
    MEM_RD    = 4'd5,
    MEM_WR    = 4'd6,
    ECHO      = 4'd7,
    STATUS    = 4'd8,
    LOOPBACK  = 4'd9
  } cmd_e;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [3:0] OP_SET_ADDR  = 4'h0;
  localparam logic [3:0] OP_ROM_MASK  = 4'h1;
  localparam logic [3:0] OP_SRAM_MASK = 4'h2;
  localparam logic [3:0] OP_MAPPER    = 4'h3;
  localparam logic [3:0] OP_MEM_RD    = 4'h8;
  localparam logic [3:0] OP_MEM_WR    = 4'h9;
  localparam logic [3:0] OP_SYS       = 4'hF;
  localparam logic [7:0] OP_ECHO      = 8'hF0;
  localparam logic [7:0] OP_STATUS    = 8'hF1;
  localparam logic [7:0] OP_LOOPBACK  = 8'hFF;

  localparam logic [7:0] ECHO_VALUE = 8'hA5;

  // status byte: wait flag on top, credits in the low bits
  localparam int STAT_WAIT_BIT = 7;

  function automatic cmd_e decode_cmd(input logic [7:0] op);
    cmd_e c;
    case (op[7:4])
      OP_SET_ADDR:  c = SET_ADDR;
      OP_ROM_MASK:  c = ROM_MASK;
      OP_SRAM_MASK: c = SRAM_MASK;
      OP_MAPPER:    c = MAPPER;
      OP_MEM_RD:    c = MEM_RD;
      OP_MEM_WR:    c = MEM_WR;
      OP_SYS: begin
        case (op)
          OP_ECHO:     c = ECHO;
          OP_STATUS:   c = STATUS;
          OP_LOOPBACK: c = LOOPBACK;
          default:     c = NONE;
        endcase
      end
      default:      c = NONE;
    endcase
    return c;
  endfunction

  function automatic logic [7:0] status_byte(input logic waiting,
                                             input logic [CREDIT_W-1:0] credits);
    logic [7:0] s;
    s = '0;
    s[STAT_WAIT_BIT] = waiting;
    s[CREDIT_W-1:0] = credits;
    return s;
  endfunction

endpackage

`default_nettype wire

//--- rtl/spi_byte_if.sv
`timescale 1ns/10ps
`default_nettype none

interface spi_byte_if;
  import mcu_pkg::*;

  logic       byte_valid;
  logic [7:0] byte_data;
  byte_idx_t  byte_idx;
  logic       frame_start;
  // next byte to send back on miso
  logic [7:0] reply_byte;

  modport rx (
    output byte_valid,
    output byte_data,
    output byte_idx,
    output frame_start,
    input  reply_byte
  );

  modport ctrl (
    input  byte_valid,
    input  byte_data,
    input  byte_idx,
    input  frame_start,
    output reply_byte
  );

endinterface

`default_nettype wire

//--- rtl/spi_byte_rx.sv
`timescale 1ns/10ps
`default_nettype none

module spi_byte_rx (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sck,
  input  logic       mosi,
  input  logic       ss_n,
  output logic       miso,
  spi_byte_if.rx     bus
);
  import mcu_pkg::*;

  logic [1:0] sck_sync;
  logic [1:0] mosi_sync;
  logic [1:0] ss_sync;
  logic       sck_q;
  logic       ss_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       frame_active;
  logic [2:0] bit_cnt;
  byte_idx_t  idx_cnt;
  logic [6:0] rx_sh;
  logic [6:0] tx_sh;

  ////////////////////////////////////////////////////////////
  // input synchronizers and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_sync  <= '0;
      mosi_sync <= '0;
      ss_sync   <= '1;
      sck_q     <= 1'b0;
      ss_q      <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      mosi_sync <= {mosi_sync[0], mosi};
      ss_sync   <= {ss_sync[0], ss_n};
      sck_q     <= sck_sync[1];
      ss_q      <= ss_sync[1];
    end
  end

  assign sck_rise     = sck_sync[1] & ~sck_q;
  assign sck_fall     = ~sck_sync[1] & sck_q;
  assign frame_active = ~ss_sync[1];

  // bit and byte counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt         <= '0;
      idx_cnt         <= '0;
      bus.byte_valid  <= 1'b0;
      bus.frame_start <= 1'b0;
    end else begin
      bus.byte_valid  <= 1'b0;
      bus.frame_start <= ~ss_sync[1] & ss_q;
      if (!frame_active) begin
        bit_cnt <= '0;
        idx_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          bus.byte_valid <= 1'b1;
          if (idx_cnt != IDX_MAX)
            idx_cnt <= idx_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_active && sck_rise) begin
      rx_sh <= {rx_sh[5:0], mosi_sync[1]};
      if (bit_cnt == 3'd7) begin
        bus.byte_data <= {rx_sh, mosi_sync[1]};
        bus.byte_idx  <= idx_cnt;
      end
    end
    // reply taken on the first falling edge of a byte
    if (frame_active && sck_fall) begin
      if (bit_cnt == 3'd1)
        tx_sh <= bus.reply_byte[6:0];
      else
        tx_sh <= {tx_sh[5:0], 1'b0};
    end
  end

  // msb goes out before the first rising edge (mode 0)
  assign miso = frame_active & ((bit_cnt == 3'd0) ? bus.reply_byte[7] : tx_sh[6]);

endmodule

`default_nettype wire

//--- rtl/cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_ctrl (
  input  logic                        clk,
  input  logic                        arst_n,
  spi_byte_if.ctrl                    bus,
  input  logic                        req_issued,
  output logic [2:0]                  mapper,
  output logic [mcu_pkg::ADDR_W-1:0]  rom_mask,
  output logic [mcu_pkg::ADDR_W-1:0]  sram_mask,
  output mcu_pkg::cmd_e               cmd,
  output logic                        addr_load,
  output mcu_pkg::byte_idx_t          addr_load_idx,
  output logic                        addr_inc,
  output logic                        rd_start,
  output logic                        wr_start,
  output logic [7:0]                  wr_data
);
  import mcu_pkg::*;

  cmd_e new_cmd;
  cmd_e active_cmd;
  logic cmd_byte;
  logic param_byte;
  logic three_byte_param;

  // byte-wise load of a 24 bit mask, high byte first
  function automatic logic [ADDR_W-1:0] load_mask_byte(input logic [ADDR_W-1:0] m,
                                                       input byte_idx_t idx,
                                                       input logic [7:0] d);
    logic [ADDR_W-1:0] r;
    r = m;
    case (idx)
      4'd1:    r[23:16] = d;
      4'd2:    r[15:8]  = d;
      4'd3:    r[7:0]   = d;
      default: r = m;
    endcase
    return r;
  endfunction

  assign cmd_byte         = bus.byte_valid && (bus.byte_idx == '0);
  assign param_byte       = bus.byte_valid && (bus.byte_idx != '0);
  assign three_byte_param = param_byte && (bus.byte_idx <= 4'd3);
  assign new_cmd          = decode_cmd(bus.byte_data);
  // command byte acts on its own decode, later bytes on the latched one
  assign active_cmd       = (bus.byte_idx == '0) ? new_cmd : cmd;

  ////////////////////////////////////////////////////////////
  // command latch and config registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd    <= NONE;
      mapper <= '0;
    end else if (cmd_byte) begin
      cmd <= new_cmd;
      if (new_cmd == MAPPER)
        mapper <= bus.byte_data[2:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rom_mask  <= '0;
      sram_mask <= '0;
    end else if (three_byte_param) begin
      if (cmd == ROM_MASK)
        rom_mask <= load_mask_byte(rom_mask, bus.byte_idx, bus.byte_data);
      if (cmd == SRAM_MASK)
        sram_mask <= load_mask_byte(sram_mask, bus.byte_idx, bus.byte_data);
    end
  end

  // address bytes go straight to the pointer
  assign addr_load     = three_byte_param && (cmd == SET_ADDR);
  assign addr_load_idx = bus.byte_idx;

  // memory strobes
  assign rd_start = bus.byte_valid && (active_cmd == MEM_RD);
  assign wr_start = param_byte && (cmd == MEM_WR);
  assign wr_data  = bus.byte_data;

  // step the pointer once the request has left
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      addr_inc <= 1'b0;
    else
      addr_inc <= req_issued;
  end

endmodule

`default_nettype wire

//--- rtl/addr_ptr.sv
`timescale 1ns/10ps
`default_nettype none

module addr_ptr (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        load,
  input  mcu_pkg::byte_idx_t          load_idx,
  input  logic [7:0]                  load_data,
  input  logic                        inc,
  output logic [mcu_pkg::ADDR_W-1:0]  addr
);
  import mcu_pkg::*;

  localparam int LOW_W = ADDR_W - 8;

  ////////////////////////////////////////////////////////////
  // address register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr <= '0;
    end else if (load) begin
      case (load_idx)
        // high byte clears the rest
        4'd1:    addr <= {load_data, {LOW_W{1'b0}}};
        4'd2:    addr[15:8] <= load_data;
        4'd3:    addr[7:0]  <= load_data;
        default: addr <= addr;
      endcase
    end else if (inc) begin
      // wraps at 24 bits
      addr <= addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_req.sv
`timescale 1ns/10ps
`default_nettype none

module mem_req #(
  parameter int MEM_CREDITS = 4
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          rd_start,
  input  logic                          wr_start,
  input  logic [7:0]                    wr_data,
  input  logic [mcu_pkg::ADDR_W-1:0]    addr,
  input  logic                          mem_credit,
  input  logic                          mem_rdata_valid,
  input  logic [7:0]                    mem_rdata,
  output logic                          req_issued,
  output logic                          mem_req_valid,
  output logic                          mem_write,
  output logic [mcu_pkg::ADDR_W-1:0]    mem_addr,
  output logic [7:0]                    mem_wdata,
  output logic [7:0]                    rd_data,
  output logic                          rd_data_valid,
  output logic [mcu_pkg::CREDIT_W-1:0]  credits,
  output logic                          waiting
);
  import mcu_pkg::*;

  logic slot_valid;
  logic start;

  assign start = rd_start | wr_start;

  ////////////////////////////////////////////////////////////
  // request slot
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_valid <= 1'b0;
      mem_write  <= 1'b0;
    end else if (start) begin
      slot_valid <= 1'b1;
      mem_write  <= wr_start;
    end else if (mem_req_valid) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr  <= addr;
      mem_wdata <= wr_data;
    end
  end

  // slot goes out as soon as a credit is in hand
  assign mem_req_valid = slot_valid && (credits != '0);
  assign req_issued    = mem_req_valid;
  assign waiting       = slot_valid && (credits == '0);

  // credit counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= CREDIT_W'(MEM_CREDITS);
    end else begin
      case ({mem_credit, mem_req_valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // read data capture
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      rd_data_valid <= 1'b0;
    else
      rd_data_valid <= mem_rdata_valid;
  end

  always_ff @(posedge clk) begin
    if (mem_rdata_valid)
      rd_data <= mem_rdata;
  end

endmodule

`default_nettype wire

//--- rtl/readback_mux.sv
`timescale 1ns/10ps
`default_nettype none

module readback_mux (
  input  logic                          clk,
  input  logic                          arst_n,
  input  mcu_pkg::cmd_e                 cmd,
  input  logic [mcu_pkg::CREDIT_W-1:0]  credits,
  input  logic                          waiting,
  input  logic [7:0]                    rd_data,
  input  logic                          rd_data_valid,
  spi_byte_if.ctrl                      bus
);
  import mcu_pkg::*;

  cmd_e       cur_cmd;
  logic [7:0] reply_q;

  // on the command byte the latched command is still the old one
  assign cur_cmd = (bus.byte_idx == '0) ? decode_cmd(bus.byte_data) : cmd;

  ////////////////////////////////////////////////////////////
  // reply register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reply_q <= '0;
    end else if (bus.frame_start) begin
      reply_q <= '0;
    end else if (bus.byte_valid) begin
      case (cur_cmd)
        ECHO:     reply_q <= ECHO_VALUE;
        STATUS:   reply_q <= status_byte(waiting, credits);
        LOOPBACK: reply_q <= bus.byte_data;
        MEM_RD:   reply_q <= rd_data;
        default:  reply_q <= 8'h00;
      endcase
    end else if (rd_data_valid && (cmd == MEM_RD)) begin
      // fresh read data replaces the prefetched byte
      reply_q <= rd_data;
    end
  end

  assign bus.reply_byte = reply_q;

endmodule

`default_nettype wire

//--- rtl/mcu_cmd_top.sv
`timescale 1ns/10ps
`default_nettype none

module mcu_cmd_top #(
  parameter int MEM_CREDITS = 4
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        sck,
  input  logic                        mosi,
  input  logic                        ss_n,
  output logic                        miso,
  output logic [2:0]                  mapper,
  output logic [mcu_pkg::ADDR_W-1:0]  rom_mask,
  output logic [mcu_pkg::ADDR_W-1:0]  sram_mask,
  output logic                        mem_req_valid,
  output logic                        mem_write,
  output logic [mcu_pkg::ADDR_W-1:0]  mem_addr,
  output logic [7:0]                  mem_wdata,
  input  logic                        mem_credit,
  input  logic                        mem_rdata_valid,
  input  logic [7:0]                  mem_rdata
);
  import mcu_pkg::*;

  cmd_e                cmd;
  logic                addr_load;
  byte_idx_t           addr_load_idx;
  logic                addr_inc;
  logic                rd_start;
  logic                wr_start;
  logic [7:0]          wr_data;
  logic [ADDR_W-1:0]   addr;
  logic                req_issued;
  logic [7:0]          rd_data;
  logic                rd_data_valid;
  logic [CREDIT_W-1:0] credits;
  logic                waiting;

  spi_byte_if byte_bus ();

  spi_byte_rx u_rx (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .mosi   (mosi),
    .ss_n   (ss_n),
    .miso   (miso),
    .bus    (byte_bus.rx)
  );

  cmd_ctrl u_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .bus           (byte_bus.ctrl),
    .req_issued    (req_issued),
    .mapper        (mapper),
    .rom_mask      (rom_mask),
    .sram_mask     (sram_mask),
    .cmd           (cmd),
    .addr_load     (addr_load),
    .addr_load_idx (addr_load_idx),
    .addr_inc      (addr_inc),
    .rd_start      (rd_start),
    .wr_start      (wr_start),
    .wr_data       (wr_data)
  );

  addr_ptr u_addr (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (addr_load),
    .load_idx  (addr_load_idx),
    .load_data (byte_bus.byte_data),
    .inc       (addr_inc),
    .addr      (addr)
  );

  mem_req #(
    .MEM_CREDITS (MEM_CREDITS)
  ) u_mem (
    .clk             (clk),
    .arst_n          (arst_n),
    .rd_start        (rd_start),
    .wr_start        (wr_start),
    .wr_data         (wr_data),
    .addr            (addr),
    .mem_credit      (mem_credit),
    .mem_rdata_valid (mem_rdata_valid),
    .mem_rdata       (mem_rdata),
    .req_issued      (req_issued),
    .mem_req_valid   (mem_req_valid),
    .mem_write       (mem_write),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .rd_data         (rd_data),
    .rd_data_valid   (rd_data_valid),
    .credits         (credits),
    .waiting         (waiting)
  );

  readback_mux u_rb (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd           (cmd),
    .credits       (credits),
    .waiting       (waiting),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .bus           (byte_bus.ctrl)
  );

endmodule

`default_nettype wire

//--- dv/mcu_cmd_chk.sv
`timescale 1ns/10ps
`default_nettype none

module mcu_cmd_chk #(
  parameter int MEM_CREDITS = 4
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          mem_req_valid,
  input  logic                          mem_write,
  input  logic                          mem_credit,
  input  logic [mcu_pkg::CREDIT_W-1:0]  credits
);
  import mcu_pkg::*;

  // requests not yet answered by a returned credit
  int inflight;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      inflight <= 0;
    else
      inflight <= inflight + int'(mem_req_valid) - int'(mem_credit);
  end

  ////////////////////////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////////////////////////
  credit_limit: assert property (
    @(posedge clk) disable iff (!arst_n)
    credits <= CREDIT_W'(MEM_CREDITS)
  ) else $error("credit counter above the configured number of credits");

  // no request once every credit is out at the memory
  req_needs_credit: assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_req_valid |-> (inflight < MEM_CREDITS)
  ) else $error("memory request issued with zero credits");

  ////////////////////////////////////////////////////////////
  // reset state
  ////////////////////////////////////////////////////////////
  quiet_in_reset: assert property (
    @(posedge clk)
    !arst_n |-> (!mem_req_valid && !mem_write)
  ) else $error("memory request lines active during reset");

endmodule

`default_nettype wire

//--- dv/mcu_cmd_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mcu_cmd_tb;
  import mcu_pkg::*;

  localparam int MEM_CREDITS = 4;
  localparam int HALF_SCK    = 8;
  // every byte takes well under 200 clk cycles
  localparam int NUM_BYTES   = 64;
  localparam int TIMEOUT_CYC = NUM_BYTES * 200 + 2000;

  logic                clk;
  logic                arst_n;
  logic                sck;
  logic                mosi;
  logic                ss_n;
  logic                miso;
  logic [2:0]          mapper;
  logic [ADDR_W-1:0]   rom_mask;
  logic [ADDR_W-1:0]   sram_mask;
  logic                mem_req_valid;
  logic                mem_write;
  logic [ADDR_W-1:0]   mem_addr;
  logic [7:0]          mem_wdata;
  logic                mem_credit;
  logic                mem_rdata_valid;
  logic [7:0]          mem_rdata;

  logic [7:0]          tx_buf [16];
  logic [7:0]          rx_buf [16];
  logic [7:0]          mem [256];
  int                  lat_tab [64];
  int                  req_cnt;
  int                  due_q [$];
  logic                rd_q [$];
  logic [7:0]          dat_q [$];
  logic [ADDR_W-1:0]   wr_addr_log [$];
  logic [7:0]          wr_data_log [$];
  int                  cyc;
  int                  last_due;
  int                  outstanding;
  logic                hold_credits;
  int                  value_errors;
  int                  proto_errors;

  mcu_cmd_top #(
    .MEM_CREDITS (MEM_CREDITS)
  ) dut (
    .clk             (clk),
    .arst_n          (arst_n),
    .sck             (sck),
    .mosi            (mosi),
    .ss_n            (ss_n),
    .miso            (miso),
    .mapper          (mapper),
    .rom_mask        (rom_mask),
    .sram_mask       (sram_mask),
    .mem_req_valid   (mem_req_valid),
    .mem_write       (mem_write),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_credit      (mem_credit),
    .mem_rdata_valid (mem_rdata_valid),
    .mem_rdata       (mem_rdata)
  );

  bind mem_req mcu_cmd_chk #(
    .MEM_CREDITS (MEM_CREDITS)
  ) u_chk (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_req_valid (mem_req_valid),
    .mem_write     (mem_write),
    .mem_credit    (mem_credit),
    .credits       (credits)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fill pattern over the whole byte address
  function automatic logic [7:0] fill_value(input int a);
    logic [7:0] v;
    v = 8'(a * 13) ^ 8'hC3;
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // SPI master in mode 0 with msb first
  ////////////////////////////////////////////////////////////
  task automatic spi_frame(input int n);
    logic [7:0] r;
    @(posedge clk);
    ss_n <= 1'b0;
    repeat (2 * HALF_SCK) @(posedge clk);
    for (int b = 0; b < n; b++) begin
      r = '0;
      for (int i = 7; i >= 0; i--) begin
        mosi <= tx_buf[b][i];
        repeat (HALF_SCK) @(posedge clk);
        @(negedge clk);
        r = {r[6:0], miso};
        @(posedge clk);
        sck <= 1'b1;
        repeat (HALF_SCK) @(posedge clk);
        sck <= 1'b0;
      end
      rx_buf[b] = r;
      repeat (2 * HALF_SCK) @(posedge clk);
    end
    repeat (HALF_SCK) @(posedge clk);
    ss_n <= 1'b1;
    repeat (3 * HALF_SCK) @(posedge clk);
  endtask

  task automatic set_address(input logic [ADDR_W-1:0] a);
    tx_buf[0] = 8'h00;
    tx_buf[1] = a[23:16];
    tx_buf[2] = a[15:8];
    tx_buf[3] = a[7:0];
    spi_frame(4);
  endtask

  task automatic wait_writes(input string name, input int n);
    int t;
    t = 0;
    while (wr_addr_log.size() < n && t < 1000) begin
      @(posedge clk);
      t++;
    end
    if (wr_addr_log.size() < n) begin
      proto_errors++;
      $display("%s: memory writes did not arrive in time", name);
    end
  endtask

  task automatic wait_idle(input string name);
    int t;
    t = 0;
    while ((outstanding != 0 || due_q.size() != 0) && t < 1000) begin
      @(posedge clk);
      t++;
    end
    if (outstanding != 0 || due_q.size() != 0) begin
      proto_errors++;
      $display("%s: memory credits were not returned in time", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model with variable latency
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    int lat;
    int due;
    cyc++;
    mem_credit      <= 1'b0;
    mem_rdata_valid <= 1'b0;
    if (arst_n) begin
      if (mem_req_valid) begin
        lat = lat_tab[req_cnt % 64];
        req_cnt++;
        due = cyc + lat;
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        if (mem_write) begin
          mem[mem_addr[7:0]] = mem_wdata;
          wr_addr_log.push_back(mem_addr);
          wr_data_log.push_back(mem_wdata);
        end
        due_q.push_back(due);
        rd_q.push_back(!mem_write);
        dat_q.push_back(mem[mem_addr[7:0]]);
      end
      // credit returns are withheld while hold_credits is set
      if (!hold_credits && due_q.size() > 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        mem_credit      <= 1'b1;
        mem_rdata_valid <= rd_q.pop_front();
        mem_rdata       <= dat_q.pop_front();
      end
      outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
    end
  end

  no_overrun: assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_req_valid |-> (outstanding < MEM_CREDITS)
  ) else begin
    proto_errors++;
    $display("memory request issued with all credits outstanding");
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("watchdog expired before the tests completed");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    int base;
    void'($urandom(57232));
    // latencies of 2 to 6 cycles, one per request
    for (int i = 0; i < 64; i++)
      lat_tab[i] = 2 + int'($urandom % 5);
    arst_n          = 1'b0;
    sck             = 1'b0;
    mosi            = 1'b0;
    ss_n            = 1'b1;
    mem_credit      = 1'b0;
    mem_rdata_valid = 1'b0;
    mem_rdata       = 8'h00;
    hold_credits    = 1'b0;
    req_cnt         = 0;
    cyc             = 0;
    last_due        = 0;
    outstanding     = 0;
    value_errors    = 0;
    proto_errors    = 0;
    for (int i = 0; i < 256; i++)
      mem[i] = fill_value(i);
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);

    // echo and idle status
    tx_buf[0] = OP_ECHO;
    tx_buf[1] = 8'h00;
    tx_buf[2] = 8'h00;
    spi_frame(3);
    check_val("echo byte 1", 32'hA5, 32'(rx_buf[1]));
    check_val("echo byte 2", 32'hA5, 32'(rx_buf[2]));
    tx_buf[0] = OP_STATUS;
    spi_frame(3);
    check_val("status idle 1", 32'h04, 32'(rx_buf[1]));
    check_val("status idle 2", 32'h04, 32'(rx_buf[2]));

    // config registers
    tx_buf[0] = 8'h35;
    spi_frame(1);
    check_val("mapper", 32'd5, 32'(mapper));
    tx_buf[0] = 8'h10;
    tx_buf[1] = 8'hAB;
    tx_buf[2] = 8'hCD;
    tx_buf[3] = 8'hEF;
    spi_frame(4);
    check_val("rom mask", 32'hABCDEF, 32'(rom_mask));
    tx_buf[0] = 8'h20;
    tx_buf[1] = 8'h12;
    tx_buf[2] = 8'h34;
    tx_buf[3] = 8'h56;
    spi_frame(4);
    check_val("sram mask", 32'h123456, 32'(sram_mask));

    // reads with the command slot as the first reply byte
    set_address(24'h000040);
    tx_buf[0] = 8'h80;
    for (int i = 1; i <= 5; i++)
      tx_buf[i] = 8'h00;
    spi_frame(6);
    for (int i = 1; i <= 5; i++)
      check_val($sformatf("read byte %0d", i), 32'(fill_value(8'h40 + i - 1)),
                32'(rx_buf[i]));

    // writes with free credits
    set_address(24'h123480);
    base = wr_addr_log.size();
    tx_buf[0] = 8'h90;
    for (int i = 1; i <= 4; i++)
      tx_buf[i] = 8'h60 + 8'(i * 3);
    spi_frame(5);
    wait_writes("write burst", base + 4);
    for (int i = 0; i < 4 && base + i < wr_addr_log.size(); i++) begin
      check_val("write addr", 32'h123480 + i, 32'(wr_addr_log[base + i]));
      check_val("write data", 32'(tx_buf[i + 1]), 32'(wr_data_log[base + i]));
    end

    // credit back-pressure
    set_address(24'h0000A0);
    base = wr_addr_log.size();
    hold_credits <= 1'b1;
    tx_buf[0] = 8'h90;
    for (int i = 1; i <= 5; i++)
      tx_buf[i] = 8'hC0 ^ 8'(i * 17);
    spi_frame(6);
    check_val("stalled request count", 32'(base + MEM_CREDITS), 32'(wr_addr_log.size()));
    tx_buf[0] = OP_STATUS;
    tx_buf[1] = 8'h00;
    spi_frame(2);
    check_val("status while held", 32'h80, 32'(rx_buf[1]));
    hold_credits <= 1'b0;
    wait_writes("stalled burst", base + 5);
    for (int i = 0; i < 5; i++)
      check_val("stalled write data", 32'(8'hC0 ^ 8'((i + 1) * 17)), 32'(mem[8'hA0 + i]));
    for (int i = 0; i < 5 && base + i < wr_addr_log.size(); i++)
      check_val("stalled write addr", 32'h0000A0 + i, 32'(wr_addr_log[base + i]));
    wait_idle("credit release");
    tx_buf[0] = OP_STATUS;
    spi_frame(2);
    check_val("status after release", 32'h04, 32'(rx_buf[1]));

    // loopback
    tx_buf[0] = OP_LOOPBACK;
    tx_buf[1] = 8'h3C;
    tx_buf[2] = 8'h96;
    tx_buf[3] = 8'h5E;
    spi_frame(4);
    for (int i = 1; i <= 3; i++)
      check_val($sformatf("loopback byte %0d", i), 32'(tx_buf[i - 1]), 32'(rx_buf[i]));

    repeat (10) @(posedge clk);
    $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/mcu_pkg.sv
rtl/spi_byte_if.sv
rtl/spi_byte_rx.sv
rtl/cmd_ctrl.sv
rtl/addr_ptr.sv
rtl/mem_req.sv
rtl/readback_mux.sv
rtl/mcu_cmd_top.sv
dv/mcu_cmd_chk.sv
dv/mcu_cmd_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mcu_cmd_tb \
  -f filelist.f -o mcu_cmd_sim

./obj_dir/mcu_cmd_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
else
  exit 1
fi
